/* Makefile */
VERILATOR ?= verilator
TOP       ?= uartLinkTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/uartLinkTb.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module uartLinkTb;
   import uart_pkg::*;

   // One serial bit in clk cycles
   localparam int BitClks = `UART_OVERSAMPLE * `UART_BAUD_DIV;
   localparam int Depth   = `UART_FIFO_DEPTH;
   // Bound for every wait loop
   localparam int Limit   = 100 * BitClks;

   logic       clk;
   logic       rstN;
   charLen_t   cfgLength;
   parity_t    cfgParity;
   stopBits_t  cfgStop;
   logic       txValid;
   logic [7:0] txData;
   logic       txCredit;
   logic       txd;
   logic       rxd;
   logic       rxValid;
   logic [7:0] rxData;
   logic       rxParityErr;
   logic       rxFrameErr;
   logic       rxCredit;
   logic       rxOverrun;

   logic       corrupt;
   logic       afterReset;
   logic       overrunOk;
   logic [9:0] rxWord;
   logic [9:0] expQ[$];
   logic [9:0] expHead;
   logic       expAny;
   int         hostCredits;
   int         rxGrants;
   int         creditPulses;
   int         overruns;
   int         sent;
   int         checkErrors;
   int         timeouts;
   string      testName;

   // Loopback with an optional bit flip on the wire
   assign rxd    = txd ^ corrupt;
   assign rxWord = {rxData, rxParityErr, rxFrameErr};

   uartLink dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Host bookkeeping and scoreboard
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (rstN)
      begin
         hostCredits  <= hostCredits + int'(txCredit) - int'(txValid);
         rxGrants     <= rxGrants + int'(rxCredit) - int'(rxValid);
         creditPulses <= creditPulses + int'(txCredit);
         overruns     <= overruns + int'(rxOverrun);
         if (rxValid && expQ.size() > 0)
            void'(expQ.pop_front());
         // Head after this cycle's pop
         expHead <= (expQ.size() > 0) ? expQ[0] : '0;
         expAny  <= (expQ.size() > 0);
      end
   end

   // Delivered character equals the oldest expected one
   assert property (@(posedge clk) disable iff (!rstN)
      rxValid && expAny |-> rxWord == expHead)
      else
      begin
         checkErrors++;
         $display("mismatch %s expected %h actual %h", testName,
                  $sampled(expHead), $sampled(rxWord));
      end

   assert property (@(posedge clk) disable iff (!rstN) rxValid |-> expAny)
      else
      begin
         checkErrors++;
         $display("%s: character delivered while none was expected", testName);
      end

   // No delivery without a host grant
   assert property (@(posedge clk) disable iff (!rstN) rxValid |-> rxGrants > 0)
      else
      begin
         checkErrors++;
         $display("%s: rxValid pulsed without a receive credit", testName);
      end

   assert property (@(posedge clk) disable iff (!rstN)
      hostCredits >= 0 && hostCredits <= Depth && (!txValid || hostCredits > 0))
      else
      begin
         checkErrors++;
         $display("%s: host transmit credits out of range", testName);
      end

   assert property (@(posedge clk) disable iff (!rstN) rxOverrun |-> overrunOk)
      else
      begin
         checkErrors++;
         $display("%s: receive overrun where none was expected", testName);
      end

   // Idle outputs during and right after reset
   assert property (@(posedge clk)
      (!rstN || afterReset) |-> txd && !txCredit && !rxValid && !rxOverrun)
      else
      begin
         checkErrors++;
         $display("%s: outputs not idle around reset", testName);
      end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers, all called on the falling edge
   //////////////////////////////////////////////////////////////////////

   // Bits above the character length read as zero
   function automatic logic [7:0] activeMask(input charLen_t l);
      int nBits;
      nBits = 5 + int'(l);
      return 8'((1 << nBits) - 1);
   endfunction

   task automatic sendByte(input logic [7:0] b);
      int t;
      t = 0;
      while (hostCredits == 0 && t < Limit)
      begin
         @(negedge clk);
         t++;
      end
      if (hostCredits == 0)
      begin
         timeouts++;
         $display("%s: no transmit credit came back", testName);
      end
      else
      begin
         txValid = 1'b1;
         txData  = b;
         sent++;
         @(negedge clk);
         txValid = 1'b0;
      end
   endtask

   task automatic grantRx(input int n);
      repeat (n)
      begin
         rxCredit = 1'b1;
         @(negedge clk);
      end
      rxCredit = 1'b0;
   endtask

   // Expected record first, then an optional grant, then the byte
   task automatic sendChecked(input logic [7:0] b, input logic [1:0] errs, input bit grant);
      expQ.push_back({b & activeMask(cfgLength), errs});
      if (grant)
         grantRx(1);
      sendByte(b);
   endtask

   // Flip one whole bit, counted in bit times from the start edge
   task automatic corruptBit(input int bitPos);
      int t;
      t = 0;
      while (txd && t < Limit)
      begin
         @(negedge clk);
         t++;
      end
      if (txd)
      begin
         timeouts++;
         $display("%s: start bit never appeared on txd", testName);
      end
      else
      begin
         repeat (bitPos * BitClks) @(negedge clk);
         corrupt = 1'b1;
         repeat (BitClks) @(negedge clk);
         corrupt = 1'b0;
      end
   endtask

   // Until every expected character arrived, then let stop bits finish
   task automatic waitDrained();
      int t;
      t = 0;
      while (expQ.size() != 0 && t < Limit)
      begin
         @(negedge clk);
         t++;
      end
      if (expQ.size() != 0)
      begin
         timeouts++;
         $display("%s: %0d characters never arrived", testName, expQ.size());
      end
      repeat (2 * BitClks) @(negedge clk);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [7:0] b;
      int t;
      rstN = 1'b0;
      cfgLength = len8;
      cfgParity = parNone;
      cfgStop = stopOne;
      txValid = 1'b0;
      txData = '0;
      rxCredit = 1'b0;
      corrupt = 1'b0;
      afterReset = 1'b0;
      overrunOk = 1'b0;
      expHead = '0;
      expAny = 1'b0;
      hostCredits = Depth;
      rxGrants = 0;
      creditPulses = 0;
      overruns = 0;
      sent = 0;
      checkErrors = 0;
      timeouts = 0;
      void'($urandom(4));

      testName = "reset";
      repeat (16) @(negedge clk);
      rstN = 1'b1;
      afterReset = 1'b1;
      repeat (8) @(negedge clk);
      afterReset = 1'b0;

      // Every length, parity and stop combination
      testName = "loopback";
      for (int l = 0; l < 4; l++)
         for (int p = 0; p < 3; p++)
            for (int s = 0; s < 2; s++)
            begin
               cfgLength = charLen_t'(l);
               cfgParity = parity_t'(p);
               cfgStop = stopBits_t'(s);
               repeat (2)
               begin
                  b = 8'($urandom());
                  sendChecked(b, 2'b00, 1'b1);
               end
               waitDrained();
            end

      // Burst from the initial credits alone
      testName = "txCredits";
      cfgLength = len8;
      cfgParity = parEven;
      cfgStop = stopOne;
      // Receive credits up front, words then go back to back
      grantRx(Depth);
      for (int i = 0; i < Depth; i++)
         sendChecked(8'($urandom()), 2'b00, 1'b0);
      waitDrained();
      assert (creditPulses == sent)
      else
      begin
         checkErrors++;
         $display("mismatch %s expected %0d actual %0d", testName, sent, creditPulses);
      end

      // Receive FIFO fills, the extra character drops
      testName = "rxBackPressure";
      overrunOk = 1'b1;
      for (int i = 0; i < Depth; i++)
         sendChecked(8'($urandom()), 2'b00, 1'b0);
      sendByte(8'($urandom()));
      t = 0;
      while (overruns == 0 && t < Limit)
      begin
         @(negedge clk);
         t++;
      end
      if (overruns == 0)
      begin
         timeouts++;
         $display("%s: overrun never reported", testName);
      end
      repeat (2 * BitClks) @(negedge clk);
      overrunOk = 1'b0;
      grantRx(Depth);
      waitDrained();
      assert (overruns == 1)
      else
      begin
         checkErrors++;
         $display("mismatch %s expected 1 actual %0d", testName, overruns);
      end

      // Parity bit sits right after the data bits
      testName = "parityError";
      for (int i = 0; i < 2; i++)
      begin
         cfgLength = (i == 0) ? len8 : len5;
         cfgParity = (i == 0) ? parEven : parOdd;
         cfgStop = stopOne;
         sendChecked(8'($urandom()), 2'b10, 1'b1);
         corruptBit(6 + int'(cfgLength));
         waitDrained();
      end

      // First stop bit forced low
      testName = "frameError";
      cfgLength = len7;
      cfgParity = parOdd;
      cfgStop = stopTwo;
      sendChecked(8'($urandom()), 2'b01, 1'b1);
      corruptBit(9);
      waitDrained();

      $display("%0d check errors, %0d timeouts", checkErrors, timeouts);
      if (checkErrors == 0 && timeouts == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* include/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Slots in each credit FIFO
`define UART_FIFO_DEPTH 4

// Clock cycles per baud tick
// Kept small so simulation stays short
`define UART_BAUD_DIV 4

// Baud ticks per serial bit
`define UART_OVERSAMPLE 16

// Width of the per-bit tick counter
// Must hold UART_OVERSAMPLE - 1
`define UART_BIT_CNT_W 4

`endif

/* logic/baudGen.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module baudGen (
   input logic   clk,
   input logic   rstN,
   lineCfgIf.gen cfg
);

   // Wide enough for any divisor, including one
   localparam int DivW = $clog2(`UART_BAUD_DIV + 1);
   localparam logic [DivW-1:0] LastCnt = DivW'(`UART_BAUD_DIV - 1);

   logic [DivW-1:0] divCnt;

   // Free-running divider, tick on every wrap
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         divCnt   <= '0;
         cfg.tick <= 1'b0;
      end
      else
      begin
         divCnt   <= (divCnt == LastCnt) ? '0 : divCnt + 1'b1;
         cfg.tick <= (divCnt == LastCnt);
      end
   end

endmodule

/* logic/creditFifo.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module creditFifo #(
   parameter type T            = logic [7:0],
   parameter int  INIT_CREDITS = 1
) (
   input  logic clk,
   input  logic rstN,
   input  logic inValid,
   input  T     inData,
   output logic inCredit,
   output logic outValid,
   output T     outData,
   input  logic outCredit,
   output logic overrun
);

   localparam int Depth = `UART_FIFO_DEPTH;
   localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
   localparam int CntW  = $clog2(Depth + 1);
   // Room for a host that grants well ahead
   localparam int CredW = 8;

   T                 mem [Depth];
   logic [PtrW-1:0]  wrPtr;
   logic [PtrW-1:0]  rdPtr;
   logic [CntW-1:0]  count;
   logic [CredW-1:0] credits;
   logic             full;
   logic             doPush;
   logic             doPop;

   assign full   = (count == CntW'(Depth));
   assign doPush = inValid && !full;
   // Issue only with both a word and a downstream credit
   assign doPop  = (count != '0) && (credits != '0);

   // Head word goes out in the pop cycle
   assign outValid = doPop;
   assign outData  = mem[rdPtr];

   // Storage
   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= inData;
   end

   //////////////////////////////////////////////////////////////////////
   // Pointers, occupancy and credits
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         wrPtr    <= '0;
         rdPtr    <= '0;
         count    <= '0;
         credits  <= CredW'(INIT_CREDITS);
         inCredit <= 1'b0;
         overrun  <= 1'b0;
      end
      else
      begin
         if (doPush)
            wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop)
            rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
         count    <= count + CntW'(doPush) - CntW'(doPop);
         credits  <= credits + CredW'(outCredit) - CredW'(doPop);
         // One credit upstream per freed slot
         inCredit <= doPop;
         // Word dropped, buffer full
         overrun  <= inValid && full;
      end
   end

   // Returned credits never wrap the counter
   assert property (@(posedge clk) disable iff (!rstN)
      outCredit && !doPop |-> credits != '1)
      else $error("creditFifo credit counter overflowed");

endmodule

/* logic/lineCfgIf.sv */
`timescale 1ns/1ns

interface lineCfgIf;
   import uart_pkg::*;

   // Shared 16x clock enable
   logic      tick;

   // Line format, static while the link is idle
   charLen_t  length;
   parity_t   parity;
   stopBits_t stop;

   // Tick source
   modport gen (output tick);

   // Serializer and deserializer both only look
   modport txSide (input tick, length, parity, stop);
   modport rxSide (input tick, length, parity, stop);

endinterface

/* logic/uartLink.sv */
`timescale 1ns/1ns

module uartLink (
   input  logic                clk,
   input  logic                rstN,
   input  uart_pkg::charLen_t  cfgLength,
   input  uart_pkg::parity_t   cfgParity,
   input  uart_pkg::stopBits_t cfgStop,
   input  logic                txValid,
   input  logic [7:0]          txData,
   output logic                txCredit,
   output logic                txd,
   input  logic                rxd,
   output logic                rxValid,
   output logic [7:0]          rxData,
   output logic                rxParityErr,
   output logic                rxFrameErr,
   input  logic                rxCredit,
   output logic                rxOverrun
);
   import uart_pkg::*;

   logic       txLoad;
   logic [7:0] txWord;
   logic       txFree;
   logic       rxCharValid;
   rxChar_t    rxChar;
   rxChar_t    rxHead;

   // Tick and line format shared by both directions
   lineCfgIf cfg ();
   assign cfg.length = cfgLength;
   assign cfg.parity = cfgParity;
   assign cfg.stop   = cfgStop;

   baudGen uBaud (.clk, .rstN, .cfg(cfg.gen));

   //////////////////////////////////////////////////////////////////////
   // Transmit path
   //////////////////////////////////////////////////////////////////////

   // Serializer is unbuffered, one credit
   creditFifo #(.T(logic [7:0]), .INIT_CREDITS(1)) uTxFifo (
      .clk, .rstN,
      .inValid(txValid), .inData(txData), .inCredit(txCredit),
      .outValid(txLoad), .outData(txWord), .outCredit(txFree),
      .overrun()
   );

   uartTx uTx (
      .clk, .rstN, .cfg(cfg.txSide),
      .load(txLoad), .data(txWord), .credit(txFree), .txd
   );

   //////////////////////////////////////////////////////////////////////
   // Receive path
   //////////////////////////////////////////////////////////////////////

   uartRx uRx (
      .clk, .rstN, .cfg(cfg.rxSide),
      .rxd, .charValid(rxCharValid), .charOut(rxChar)
   );

   // Host grants every delivery, none at reset
   creditFifo #(.T(rxChar_t), .INIT_CREDITS(0)) uRxFifo (
      .clk, .rstN,
      .inValid(rxCharValid), .inData(rxChar), .inCredit(),
      .outValid(rxValid), .outData(rxHead), .outCredit(rxCredit),
      .overrun(rxOverrun)
   );

   assign rxData      = rxHead.data;
   assign rxParityErr = rxHead.parityErr;
   assign rxFrameErr  = rxHead.frameErr;

endmodule

/* logic/uartRx.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module uartRx (
   input  logic              clk,
   input  logic              rstN,
   lineCfgIf.rxSide          cfg,
   input  logic              rxd,
   output logic              charValid,
   output uart_pkg::rxChar_t charOut
);
   import uart_pkg::*;

   localparam int BitCntW = `UART_BIT_CNT_W;
   localparam logic [BitCntW-1:0] LastTick = BitCntW'(`UART_OVERSAMPLE - 1);
   localparam logic [BitCntW-1:0] HalfTick = BitCntW'(`UART_OVERSAMPLE / 2 - 1);

   typedef enum logic [2:0] {
      rHunt, rStart, rData, rParity, rStop
   } rxState_t;

   rxState_t           state;
   logic [1:0]         rxSync;
   logic               rxS;
   logic               rxPrev;
   logic               fallEdge;
   logic [BitCntW-1:0] tickCnt;
   logic               sampleNow;
   logic [2:0]         bitIdx;
   logic [2:0]         lastIdx;
   logic [7:0]         shReg;
   logic               parBit;

   assign rxS       = rxSync[1];
   assign fallEdge  = rxPrev && !rxS;
   assign lastIdx   = 3'd4 + 3'(cfg.length);
   // Middle of the current bit
   assign sampleNow = cfg.tick && (tickCnt == '0) && (state != rHunt);

   //////////////////////////////////////////////////////////////////////
   // Synchronizer, edge detect, sample timing
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         rxSync    <= 2'b11;
         rxPrev    <= 1'b1;
         tickCnt   <= '0;
         state     <= rHunt;
         bitIdx    <= '0;
         charValid <= 1'b0;
      end
      else
      begin
         rxSync <= {rxSync[0], rxd};
         rxPrev <= rxS;
         // Half a bit to the start-bit middle, then whole bits
         if (state == rHunt)
            tickCnt <= HalfTick;
         else if (cfg.tick)
            tickCnt <= (tickCnt == '0) ? LastTick : tickCnt - 1'b1;
         case (state)
            rHunt:
               if (fallEdge)
                  state <= rStart;
            // Glitch shorter than half a bit goes back to hunting
            rStart:
               if (sampleNow)
               begin
                  bitIdx <= '0;
                  state  <= rxS ? rHunt : rData;
               end
            rData:
               if (sampleNow)
               begin
                  bitIdx <= bitIdx + 1'b1;
                  if (bitIdx == lastIdx)
                     state <= (cfg.parity == parNone) ? rStop : rParity;
               end
            rParity:
               if (sampleNow)
                  state <= rStop;
            // Only the first stop bit is checked
            rStop:
               if (sampleNow)
                  state <= rHunt;
            default:
               state <= rHunt;
         endcase
         charValid <= (state == rStop) && sampleNow;
      end
   end

   // Character assembly
   always_ff @(posedge clk)
   begin
      if (state == rStart && sampleNow)
         shReg <= '0;
      if (state == rData && sampleNow)
         shReg[bitIdx] <= rxS;
      if (state == rParity && sampleNow)
         parBit <= rxS;
      if (state == rStop && sampleNow)
      begin
         charOut.data      <= shReg;
         // Received parity against the recomputed one
         charOut.parityErr <= (cfg.parity != parNone) &&
                              (parBit ^ (^shReg) ^ (cfg.parity == parOdd));
         charOut.frameErr  <= !rxS;
      end
   end

   // Start bit is confirmed within half a bit of its edge
   assert property (@(posedge clk) disable iff (!rstN)
      (state == rStart) |-> (tickCnt <= HalfTick))
      else $error("uartRx start-bit counter ran past the half-bit point");

endmodule

/* logic/uartTx.sv */
`timescale 1ns/1ns
`include "uart_macros.svh"

module uartTx (
   input  logic     clk,
   input  logic     rstN,
   lineCfgIf.txSide cfg,
   input  logic     load,
   input  logic [7:0] data,
   output logic     credit,
   output logic     txd
);
   import uart_pkg::*;

   localparam int BitCntW = `UART_BIT_CNT_W;
   localparam logic [BitCntW-1:0] LastTick = BitCntW'(`UART_OVERSAMPLE - 1);

   typedef enum logic [2:0] {
      sIdle, sSync, sStart, sData, sParity, sStop1, sStop2, sDone
   } txState_t;

   txState_t           state;
   logic [BitCntW-1:0] tickCnt;
   logic [2:0]         bitIdx;
   logic [2:0]         lastIdx;
   logic [7:0]         txReg;
   logic [7:0]         lenMask;
   logic               bitEnd;
   logic               parBit;

   // Active data bits only
   assign lenMask = 8'hFF >> (2'd3 - 2'(cfg.length));
   assign lastIdx = 3'd4 + 3'(cfg.length);
   assign bitEnd  = cfg.tick && (tickCnt == '0);
   // Even parity over the masked byte, flipped for odd
   assign parBit  = (^txReg) ^ (cfg.parity == parOdd);

   // Character register, loaded once per character
   always_ff @(posedge clk)
   begin
      if (load && state == sIdle)
         txReg <= data & lenMask;
   end

   //////////////////////////////////////////////////////////////////////
   // Bit sequencer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         state   <= sIdle;
         tickCnt <= '0;
         bitIdx  <= '0;
      end
      else
      begin
         // 16 ticks per bit, reloaded at each bit boundary
         if (cfg.tick)
            tickCnt <= (state == sSync || tickCnt == '0) ? LastTick : tickCnt - 1'b1;
         case (state)
            sIdle:
               if (load)
                  state <= sSync;
            // Align to the tick phase
            sSync:
               if (cfg.tick)
                  state <= sStart;
            sStart:
               if (bitEnd)
               begin
                  bitIdx <= '0;
                  state  <= sData;
               end
            sData:
               if (bitEnd)
               begin
                  bitIdx <= bitIdx + 1'b1;
                  if (bitIdx == lastIdx)
                     state <= (cfg.parity == parNone) ? sStop1 : sParity;
               end
            sParity:
               if (bitEnd)
                  state <= sStop1;
            sStop1:
               if (bitEnd)
                  state <= (cfg.stop == stopTwo) ? sStop2 : sDone;
            sStop2:
               if (bitEnd)
                  state <= sDone;
            default:
               state <= sIdle;
         endcase
      end
   end

   // Line level per state, idle high
   always_comb
   begin
      case (state)
         sStart:  txd = 1'b0;
         sData:   txd = txReg[bitIdx];
         sParity: txd = parBit;
         default: txd = 1'b1;
      endcase
   end

   // Slot is free again
   assign credit = (state == sDone);

   // FIFO holds one credit, so it never loads a busy serializer
   assert property (@(posedge clk) disable iff (!rstN) load |-> state == sIdle)
      else $error("uartTx loaded while a character is in flight");

endmodule

/* logic/uart_pkg.sv */
package uart_pkg;

   // Character length, encoded as length minus five
   typedef enum logic [1:0] {
      len5 = 2'd0,
      len6 = 2'd1,
      len7 = 2'd2,
      len8 = 2'd3
   } charLen_t;

   // Parity mode
   typedef enum logic [1:0] {
      parNone = 2'd0,
      parEven = 2'd1,
      parOdd  = 2'd2
   } parity_t;

   // Stop bit count
   typedef enum logic {
      stopOne = 1'b0,
      stopTwo = 1'b1
   } stopBits_t;

   // One received character, data zero above the active length
   typedef struct packed {
      logic [7:0] data;
      logic       parityErr;
      logic       frameErr;
   } rxChar_t;

endpackage

/* verilog.f */
+incdir+include
logic/uart_pkg.sv
logic/lineCfgIf.sv
logic/baudGen.sv
logic/creditFifo.sv
logic/uartTx.sv
logic/uartRx.sv
logic/uartLink.sv
dv/uartLinkTb.sv
